// File: source/fpu_pkg.sv
`default_nettype none

package fpu_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Field types
   ////////////////////////////////////////////////////////////////////////////

   typedef logic [31:0]       float_t;  // Sign, biased exp [30:23], fraction [22:0]
   typedef logic signed [9:0] exp_t;    // Unbiased, headroom for sums and products
   typedef logic [23:0]       mant_t;   // Hidden bit at [23]

   ////////////////////////////////////////////////////////////////////////////
   // Operation and rounding codes
   ////////////////////////////////////////////////////////////////////////////

   // Any other op code is invalid
   typedef enum logic [3:0] {
      FP_ADD = 4'h0,
      FP_SUB = 4'h1,
      FP_MUL = 4'h2
   } fp_op_e;

   typedef enum logic [1:0] {
      RND_NE = 2'b00,   // Nearest, ties to even
      RND_TZ = 2'b01,   // Toward zero
      RND_UP = 2'b10,   // Toward +inf
      RND_DN = 2'b11    // Toward -inf
   } rnd_mode_e;

   ////////////////////////////////////////////////////////////////////////////
   // Internal bundles
   ////////////////////////////////////////////////////////////////////////////

   // Decoded operand
   typedef struct packed {
      logic  sign;
      exp_t  exp;       // -126 for zero and flushed subnormals
      mant_t mant;      // Zero for zero operands
      logic  is_zero;
      logic  is_inf;
      logic  is_nan;
   } unpacked_t;

   typedef struct packed {
      logic of;     // Overflow
      logic uf;     // Underflow, flushed to zero
      logic zero;   // Result is +-0
      logic ix;     // Inexact
      logic iv;     // Invalid
      logic inf;    // Result is +-inf
   } fp_flags_t;

   // Unrounded datapath result going into the normalizer.
   // Mantissa is left aligned: [55] has weight 2^1, [54] weight 2^0 at exp.
   // Only the top 25 + GUARD_BITS bits are live, the lowest of them is sticky.
   typedef struct packed {
      logic        sign;
      exp_t        exp;
      logic [55:0] mant;
   } norm_in_t;

endpackage

`default_nettype wire

// File: source/fpu_add.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_add #(
   parameter int unsigned GUARD_BITS = 3
) (
   input  fpu_pkg::unpacked_t          a,
   input  fpu_pkg::unpacked_t          b,
   input  fpu_pkg::fp_op_e             op,
   output fpu_pkg::norm_in_t           sum
);

   // Carry bit, 24 bit mantissa, guard bits with sticky at the bottom
   localparam int unsigned W = 25 + GUARD_BITS;

   logic               sign_b;      // Inverted for subtract
   logic               swap;        // b has the larger magnitude
   fpu_pkg::unpacked_t lg;          // Larger operand
   fpu_pkg::unpacked_t sm;          // Smaller operand
   logic               sign_lg;
   logic               sign_sm;
   logic               eff_sub;
   fpu_pkg::exp_t      diff;        // Never negative after swap
   logic [7:0]         shamt;
   logic [W-1:0]       f_lg;
   logic [W-1:0]       f_sm;
   logic [2*W-1:0]     sm_wide;     // Upper half kept, lower half lost
   logic               sticky;
   logic [W-1:0]       f_al;        // Aligned smaller mantissa
   logic [W-1:0]       res;

   ////////////////////////////////////////////////////////////////////////////
   // Magnitude compare and swap
   ////////////////////////////////////////////////////////////////////////////

   assign sign_b  = b.sign ^ (op == fpu_pkg::FP_SUB);
   assign swap    = (b.exp > a.exp) || ((b.exp == a.exp) && (b.mant > a.mant));

   assign lg      = swap ? b : a;
   assign sm      = swap ? a : b;
   assign sign_lg = swap ? sign_b : a.sign;
   assign sign_sm = swap ? a.sign : sign_b;
   assign eff_sub = sign_lg ^ sign_sm;

   ////////////////////////////////////////////////////////////////////////////
   // Alignment
   ////////////////////////////////////////////////////////////////////////////

   assign diff  = lg.exp - sm.exp;
   // Beyond W everything lands in the lost half anyway
   assign shamt = (diff > fpu_pkg::exp_t'(W)) ? 8'(W) : diff[7:0];

   assign f_lg    = {1'b0, lg.mant, {GUARD_BITS{1'b0}}};
   assign f_sm    = {1'b0, sm.mant, {GUARD_BITS{1'b0}}};
   assign sm_wide = {f_sm, {W{1'b0}}} >> shamt;
   assign sticky  = |sm_wide[W-1:0];
   assign f_al    = sm_wide[2*W-1 -: W] | {{(W-1){1'b0}}, sticky};

   ////////////////////////////////////////////////////////////////////////////
   // Mantissa add or subtract
   ////////////////////////////////////////////////////////////////////////////

   // Larger first, so the difference is never negative
   assign res = eff_sub ? (f_lg - f_al) : (f_lg + f_al);

   // Cancellation leaves leading zeros for the normalizer
   always_comb
   begin
      sum               = '0;
      sum.sign          = sign_lg;
      sum.exp           = lg.exp;
      sum.mant[55 -: W] = res;
   end

endmodule

`default_nettype wire

// File: source/fpu_mult.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_mult #(
   parameter int unsigned GUARD_BITS = 3
) (
   input  fpu_pkg::unpacked_t          a,
   input  fpu_pkg::unpacked_t          b,
   output fpu_pkg::norm_in_t           prod
);

   localparam int unsigned W = 25 + GUARD_BITS;   // Kept product bits

   logic [47:0] p;         // Full product, [47] weight 2^1
   logic [55:0] p_ext;     // Aligned to the norm_in_t mantissa field
   logic [55:0] lo_mask;   // Bits below the kept window
   logic        sticky;

   assign p       = a.mant * b.mant;
   assign p_ext   = {p, 8'h00};
   assign lo_mask = {56{1'b1}} >> W;
   assign sticky  = |(p_ext & lo_mask);   // Everything below the window

   always_comb
   begin
      prod               = '0;
      prod.sign          = a.sign ^ b.sign;
      prod.exp           = a.exp + b.exp;   // Unbiased, no rebias needed
      prod.mant[55 -: W] = p_ext[55 -: W] | {{(W-1){1'b0}}, sticky};
   end

endmodule

`default_nettype wire

// File: source/fpu_norm.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_norm #(
   parameter int unsigned GUARD_BITS = 3
) (
   input  fpu_pkg::rnd_mode_e          rm,
   input  fpu_pkg::norm_in_t           value,
   output fpu_pkg::float_t             result,
   output fpu_pkg::fp_flags_t          flags
);

   localparam int unsigned W = 25 + GUARD_BITS;

   logic [W-1:0]  m;         // Live window of the input
   logic [5:0]    lz;        // Leading zeros of m
   logic [W-1:0]  mn;        // Hidden bit at [W-1]
   fpu_pkg::exp_t e_n;
   logic          lsb;
   logic          rnd;
   logic          stk;
   logic          inexact;
   logic          inc;       // Rounding increment
   logic [24:0]   mant_r;    // Rounded significand plus carry
   fpu_pkg::exp_t e_r;
   fpu_pkg::exp_t e_b;       // Biased
   logic [22:0]   frac;
   logic          ovf;
   logic          unf;
   logic          to_inf;    // Overflow goes to inf, else max finite

   assign m = value.mant[55 -: W];

   ////////////////////////////////////////////////////////////////////////////
   // Normalization
   ////////////////////////////////////////////////////////////////////////////

   // Highest set bit wins
   always_comb
   begin
      lz = '0;
      for (int i = 0; i < W; i++)
      begin
         if (m[i])
            lz = 6'(W - 1 - i);
      end
   end

   assign mn  = m << lz;
   assign e_n = value.exp + fpu_pkg::exp_t'(1) - fpu_pkg::exp_t'(lz);   // [W-1] was 2^1

   always_comb
   begin
      a_hidden_bit: assert final ((m == '0) || mn[W-1])
         else $error("fpu_norm: hidden bit not set after shift");
   end

   ////////////////////////////////////////////////////////////////////////////
   // Rounding
   ////////////////////////////////////////////////////////////////////////////

   assign lsb     = mn[GUARD_BITS + 1];
   assign rnd     = mn[GUARD_BITS];
   assign stk     = |mn[GUARD_BITS-1:0];
   assign inexact = rnd | stk;

   always_comb
   begin
      case (rm)
         fpu_pkg::RND_NE: inc = rnd & (stk | lsb);   // Ties to even
         fpu_pkg::RND_TZ: inc = 1'b0;
         fpu_pkg::RND_UP: inc = inexact & ~value.sign;
         fpu_pkg::RND_DN: inc = inexact & value.sign;
         default:         inc = 1'b0;
      endcase
   end

   assign mant_r = {1'b0, mn[W-1 -: 24]} + 25'(inc);
   // Carry out means 10.000..0, shift back by one
   assign e_r    = mant_r[24] ? e_n + fpu_pkg::exp_t'(1) : e_n;
   assign frac   = mant_r[24] ? mant_r[23:1] : mant_r[22:0];
   assign e_b    = e_r + fpu_pkg::exp_t'(127);

   ////////////////////////////////////////////////////////////////////////////
   // Range check and packing
   ////////////////////////////////////////////////////////////////////////////

   assign ovf    = e_r > fpu_pkg::exp_t'(127);
   assign unf    = e_r < fpu_pkg::exp_t'(-126);
   assign to_inf = (rm == fpu_pkg::RND_NE) ||
                   ((rm == fpu_pkg::RND_UP) && !value.sign) ||
                   ((rm == fpu_pkg::RND_DN) && value.sign);

   always_comb
   begin
      flags = '0;
      if (m == '0)
      begin
         result     = {rm == fpu_pkg::RND_DN, 31'h0};   // Exact cancellation
         flags.zero = 1'b1;
      end
      else if (ovf)
      begin
         flags.of = 1'b1;
         flags.ix = 1'b1;
         if (to_inf)
         begin
            result    = {value.sign, 8'hFF, 23'h0};
            flags.inf = 1'b1;
         end
         else
            result = {value.sign, 8'hFE, 23'h7F_FFFF};   // Largest finite
      end
      else if (unf)
      begin
         result     = {value.sign, 31'h0};   // Flush, no subnormals
         flags.uf   = 1'b1;
         flags.ix   = 1'b1;
         flags.zero = 1'b1;
      end
      else
      begin
         result   = {value.sign, e_b[7:0], frac};
         flags.ix = inexact;
      end
   end

endmodule

`default_nettype wire

// File: source/fpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_core #(
   parameter int unsigned GUARD_BITS = 3
) (
   input  logic                        Clk_CI,
   input  logic                        Rst_RBI,
   input  fpu_pkg::float_t             operand_a,
   input  fpu_pkg::float_t             operand_b,
   input  fpu_pkg::rnd_mode_e          rm,
   input  fpu_pkg::fp_op_e             op,
   input  logic                        enable,
   input  logic                        stall,
   output fpu_pkg::float_t             result,
   output fpu_pkg::fp_flags_t          flags
);

   fpu_pkg::unpacked_t ua;
   fpu_pkg::unpacked_t ub;
   fpu_pkg::norm_in_t  sum;         // Adder output
   fpu_pkg::norm_in_t  prod;        // Multiplier output
   fpu_pkg::norm_in_t  norm_in;
   fpu_pkg::float_t    norm_res;
   fpu_pkg::fp_flags_t norm_flags;
   fpu_pkg::float_t    res_d;
   fpu_pkg::fp_flags_t flags_d;
   logic               op_valid;
   logic               sign_b;      // b sign as seen by the adder
   logic               sign_mul;

   // Field decode, subnormals flushed to zero
   function automatic fpu_pkg::unpacked_t unpack(fpu_pkg::float_t f);
      fpu_pkg::unpacked_t u;
      u.sign    = f[31];
      u.is_zero = (f[30:23] == 8'h00);
      u.is_inf  = (f[30:23] == 8'hFF) && (f[22:0] == '0);
      u.is_nan  = (f[30:23] == 8'hFF) && (f[22:0] != '0);
      u.exp     = u.is_zero ? fpu_pkg::exp_t'(-126)
                            : fpu_pkg::exp_t'(f[30:23]) - fpu_pkg::exp_t'(127);
      u.mant    = u.is_zero ? '0 : {1'b1, f[22:0]};
      return u;
   endfunction

   assign ua       = unpack(operand_a);
   assign ub       = unpack(operand_b);
   assign op_valid = (op == fpu_pkg::FP_ADD) || (op == fpu_pkg::FP_SUB) ||
                     (op == fpu_pkg::FP_MUL);
   assign sign_b   = ub.sign ^ (op == fpu_pkg::FP_SUB);
   assign sign_mul = ua.sign ^ ub.sign;

   ////////////////////////////////////////////////////////////////////////////
   // Datapaths and rounding
   ////////////////////////////////////////////////////////////////////////////

   fpu_add #(.GUARD_BITS(GUARD_BITS)) add_i (.a(ua), .b(ub), .op(op), .sum(sum));

   fpu_mult #(.GUARD_BITS(GUARD_BITS)) mult_i (.a(ua), .b(ub), .prod(prod));

   assign norm_in = (op == fpu_pkg::FP_MUL) ? prod : sum;

   fpu_norm #(.GUARD_BITS(GUARD_BITS)) norm_i (
      .rm     (rm),
      .value  (norm_in),
      .result (norm_res),
      .flags  (norm_flags)
   );

   // Special operands override the rounded result
   always_comb
   begin
      res_d   = norm_res;
      flags_d = norm_flags;
      if (!op_valid)
      begin
         res_d      = '0;            // Unknown op code
         flags_d    = '0;
         flags_d.iv = 1'b1;
      end
      else if (ua.is_nan || ub.is_nan ||
               ((op == fpu_pkg::FP_MUL) && ((ua.is_inf && ub.is_zero) ||
                                            (ua.is_zero && ub.is_inf))) ||
               ((op != fpu_pkg::FP_MUL) && ua.is_inf && ub.is_inf &&
                (ua.sign != sign_b)))
      begin
         res_d      = 32'h7FC0_0000; // Canonical quiet NaN
         flags_d    = '0;
         flags_d.iv = 1'b1;
      end
      else if (ua.is_inf || ub.is_inf)
      begin
         flags_d     = '0;
         flags_d.inf = 1'b1;
         if (op == fpu_pkg::FP_MUL)
            res_d = {sign_mul, 8'hFF, 23'h0};
         else
            res_d = {ua.is_inf ? ua.sign : sign_b, 8'hFF, 23'h0};
      end
      else if ((op == fpu_pkg::FP_MUL) && (ua.is_zero || ub.is_zero))
      begin
         res_d        = {sign_mul, 31'h0};
         flags_d      = '0;
         flags_d.zero = 1'b1;
      end
      else if (ua.is_zero && ub.is_zero)
      begin
         // Like signs keep the sign, unlike give +0 except under DN
         res_d        = {(ua.sign == sign_b) ? ua.sign : (rm == fpu_pkg::RND_DN), 31'h0};
         flags_d      = '0;
         flags_d.zero = 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Output register
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge Clk_CI, negedge Rst_RBI)
   begin
      if (~Rst_RBI)
      begin
         result <= '0;
         flags  <= '0;
      end
      else if (enable && !stall)
      begin
         result <= res_d;
         flags  <= flags_d;
      end
   end

   a_zero_inf_excl: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
      !(flags.zero && flags.inf))
      else $error("fpu_core: zero and inf flags both set");

   a_iv_result: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
      flags.iv |-> ((result == '0) || ((result[30:23] == 8'hFF) && (result[22:0] != '0))))
      else $error("fpu_core: IV with a result that is neither NaN nor 0");

   a_stall_hold: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
      stall |=> ($stable(result) && $stable(flags)))
      else $error("fpu_core: output changed across a stalled edge");

endmodule

`default_nettype wire

// File: source/fpu.sv
`timescale 1ns/1ps
`default_nettype none

module fpu #(
   parameter int unsigned GUARD_BITS = 3   // Guard width, 3 up to 31
) (
   // Clock and reset
   input  logic                        Clk_CI,
   input  logic                        Rst_RBI,

   // Operands and controls
   input  fpu_pkg::float_t             operand_a,
   input  fpu_pkg::float_t             operand_b,
   input  fpu_pkg::rnd_mode_e          rm,
   input  fpu_pkg::fp_op_e             op,
   input  logic                        enable,   // Loads output register
   input  logic                        stall,    // Freezes both stages

   // Registered result
   output fpu_pkg::float_t             result,
   output fpu_pkg::fp_flags_t          flags
);

   // Input stage
   fpu_pkg::float_t    operand_a_q;
   fpu_pkg::float_t    operand_b_q;
   fpu_pkg::rnd_mode_e rm_q;
   fpu_pkg::fp_op_e    op_q;

   ////////////////////////////////////////////////////////////////////////////
   // Input register
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge Clk_CI, negedge Rst_RBI)
   begin
      if (~Rst_RBI)
      begin
         operand_a_q <= '0;
         operand_b_q <= '0;
         rm_q        <= fpu_pkg::RND_NE;
         op_q        <= fpu_pkg::FP_ADD;
      end
      else if (~stall)   // Hold pending operation while stalled
      begin
         operand_a_q <= operand_a;
         operand_b_q <= operand_b;
         rm_q        <= rm;
         op_q        <= op;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Core with output register
   ////////////////////////////////////////////////////////////////////////////

   fpu_core #(
      .GUARD_BITS (GUARD_BITS)
   ) core_i (
      .Clk_CI    (Clk_CI),
      .Rst_RBI   (Rst_RBI),
      .operand_a (operand_a_q),
      .operand_b (operand_b_q),
      .rm        (rm_q),
      .op        (op_q),
      .enable    (enable),      // Raw level, not registered
      .stall     (stall),
      .result    (result),
      .flags     (flags)
   );

endmodule

`default_nettype wire

// File: tb/fpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_checker (
   input  logic        Clk_CI,
   input  logic        Rst_RBI,
   input  logic        enable,
   input  logic        stall,
   input  logic [31:0] result,
   input  logic [5:0]  flags    // {of, uf, zero, ix, iv, inf}
);

   // Expected {result, flags}, one entry per output register load
   logic [37:0] expected_q[$];
   logic [37:0] exp_cur;        // What the output register holds now
   int          errors = 0;
   int          loads  = 0;     // Number of loads seen
   int          checks = 0;

   ////////////////////////////////////////////////////////////////////////////
   // Model side
   ////////////////////////////////////////////////////////////////////////////

   task automatic push_expected(input logic [37:0] value);
      expected_q.push_back(value);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Compare on every edge
   ////////////////////////////////////////////////////////////////////////////

   // Outputs read here still show the value of the previous cycle
   always @(posedge Clk_CI)
   begin
      if (!Rst_RBI)
         exp_cur = '0;   // Both registers clear
      else
      begin
         checks++;
         if (result !== exp_cur[37:6])
         begin
            $display("** Error at %0t: result is %h, expected %h",
                     $time, result, exp_cur[37:6]);
            errors++;
         end
         if (flags !== exp_cur[5:0])
         begin
            $display("** Error at %0t: flags is %b, expected %b",
                     $time, flags, exp_cur[5:0]);
            errors++;
         end
         // This edge loads the output register
         if (enable && !stall)
         begin
            loads++;
            if (expected_q.size() == 0)
            begin
               $display("Checker at %0t: output loaded with no expected result queued",
                        $time);
               errors++;
            end
            else
               exp_cur = expected_q.pop_front();
         end
      end
   end

endmodule

`default_nettype wire

// File: tb/tb_fpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fpu;

   localparam int N_HOLD   = 12;
   localparam int N_NORM   = 400;
   localparam int N_RANGE  = 200;
   localparam int N_SPEC   = 200;
   localparam int N_CANC   = 200;
   localparam int N_ZERO   = 8;
   localparam int N_STREAM = 300;
   localparam int N_DRAIN  = 3;
   localparam int NUM_OPS  = N_HOLD + N_NORM + N_RANGE + N_SPEC + N_CANC + N_ZERO + N_STREAM
                             + N_DRAIN;
   localparam int CYCLE_LIMIT = 4 * NUM_OPS + 20;

   logic                 Clk_CI = 1'b0;
   logic                 Rst_RBI = 1'b0;
   fpu_pkg::float_t      operand_a = '0;
   fpu_pkg::float_t      operand_b = '0;
   fpu_pkg::rnd_mode_e   rm = fpu_pkg::RND_NE;
   fpu_pkg::fp_op_e      op = fpu_pkg::FP_ADD;
   logic                 enable = 1'b0;
   logic                 stall = 1'b0;
   fpu_pkg::float_t      result;
   fpu_pkg::fp_flags_t   flags;

   logic [31:0] lfsr = 32'h6b7c_5b42;
   logic [69:0] in_reg = '0;     // Model of the input register {a, b, rm, op}
   int          cycles = 0;
   int          other_errors = 0;

   always #50 Clk_CI = ~Clk_CI;   // 100 ns period

   fpu #(.GUARD_BITS(3)) dut_i (
      .Clk_CI, .Rst_RBI, .operand_a, .operand_b, .rm, .op,
      .enable, .stall, .result, .flags
   );

   fpu_checker chk_i (
      .Clk_CI, .Rst_RBI, .enable, .stall, .result, .flags
   );

   ////////////////////////////////////////////////////////////////////////////
   // Random source
   ////////////////////////////////////////////////////////////////////////////

   // One Galois step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
      end
      return v;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Reference model, exact value rounded once
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [37:0] model_op(input logic [31:0] a, input logic [31:0] b,
                                            input logic [1:0] md, input logic [3:0] code);
      logic        sa, sb, sl, ss, s, ix, inc, za, zb, ia, ib, na, nb;
      int          ea, eb, el, es, d, e2, p, sh, eu;
      logic [63:0] ma, mb, ml, msm, full, al, mag, kept, rem, half;
      sa = a[31];
      sb = b[31] ^ (code == 4'h1);   // Effective sign of b
      za = (a[30:23] == 0);          // Subnormals read as zero
      zb = (b[30:23] == 0);
      ia = (a[30:23] == 8'hFF) && (a[22:0] == 0);
      ib = (b[30:23] == 8'hFF) && (b[22:0] == 0);
      na = (a[30:23] == 8'hFF) && (a[22:0] != 0);
      nb = (b[30:23] == 8'hFF) && (b[22:0] != 0);
      ea = int'(a[30:23]) - 127;
      eb = int'(b[30:23]) - 127;
      ma = za ? 64'd0 : {40'd0, 1'b1, a[22:0]};
      mb = zb ? 64'd0 : {40'd0, 1'b1, b[22:0]};
      if (code > 4'h2)
         return {32'h0, 6'b000010};
      if (na || nb || ((code == 4'h2) && ((ia && zb) || (za && ib))) ||
          ((code != 4'h2) && ia && ib && (sa != sb)))
         return {32'h7FC0_0000, 6'b000010};
      if (ia || ib)
      begin
         if (code == 4'h2)
            s = a[31] ^ b[31];
         else
            s = ia ? sa : sb;
         return {s, 8'hFF, 23'h0, 6'b000001};
      end
      if ((code == 4'h2) && (za || zb))
         return {a[31] ^ b[31], 31'h0, 6'b001000};
      if (za && zb)
         return {(sa == sb) ? sa : (md == 2'd3), 31'h0, 6'b001000};
      if (code == 4'h2)
      begin
         mag = ma * mb;               // Exact 48 bit product
         e2  = ea + eb - 46;
         s   = a[31] ^ b[31];
      end
      else
      begin
         if (za) ea = eb;             // Zero takes the other exponent
         if (zb) eb = ea;
         if ((ea > eb) || ((ea == eb) && (ma >= mb)))
         begin
            ml  = ma;
            el  = ea;
            sl  = sa;
            msm = mb;
            es  = eb;
            ss  = sb;
         end
         else
         begin
            ml  = mb;
            el  = eb;
            sl  = sb;
            msm = ma;
            es  = ea;
            ss  = sa;
         end
         d    = el - es;
         full = msm << 32;            // 32 spare bits below the mantissa
         if (d >= 64)
            al = {63'd0, full != 0};
         else
            al = (full >> d) | {63'd0, (full & ((64'd1 << d) - 1)) != 0};
         mag = (sl == ss) ? (ml << 32) + al : (ml << 32) - al;
         e2  = el - 55;
         s   = sl;
         if (mag == 0)
            return {md == 2'd3, 31'h0, 6'b001000};   // Exact zero sum
      end
      p = 0;
      for (int i = 0; i < 64; i++)
         if (mag[i]) p = i;
      sh = p - 23;
      if (sh > 0)
      begin
         kept = mag >> sh;
         rem  = mag & ((64'd1 << sh) - 1);
         half = 64'd1 << (sh - 1);
      end
      else
      begin
         kept = mag << (-sh);
         rem  = 0;
         half = 0;
      end
      ix = (rem != 0);
      case (md)
         2'd0:    inc = ix && ((rem > half) || ((rem == half) && kept[0]));
         2'd2:    inc = ix && !s;
         2'd3:    inc = ix && s;
         default: inc = 1'b0;
      endcase
      kept = kept + inc;
      if (kept[24])
      begin
         kept = kept >> 1;
         sh++;
      end
      eu = e2 + sh + 23;
      if (eu > 127)
      begin
         if ((md == 2'd0) || ((md == 2'd2) && !s) || ((md == 2'd3) && s))
            return {s, 8'hFF, 23'h0, 6'b100101};
         return {s, 8'hFE, 23'h7F_FFFF, 6'b100100};
      end
      if (eu < -126)
         return {s, 31'h0, 6'b011100};   // Flush to signed zero
      return {s, 8'(eu + 127), kept[22:0], 3'b000, ix, 2'b00};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   // One cycle; drive after the edge, predict what the next edge does
   task automatic apply(input logic [31:0] a, input logic [31:0] b, input logic [1:0] md,
                        input logic [3:0] code, input logic en, input logic st);
      @(posedge Clk_CI);
      #10;
      operand_a = a;
      operand_b = b;
      rm        = fpu_pkg::rnd_mode_e'(md);
      op        = fpu_pkg::fp_op_e'(code);
      enable    = en;
      stall     = st;
      if (en && !st)
         chk_i.push_expected(model_op(in_reg[69:38], in_reg[37:6], in_reg[5:4], in_reg[3:0]));
      if (!st)
         in_reg = {a, b, md, code};
   endtask

   function automatic logic [31:0] make_float(input int lo, input int span_bits);
      return {1'(take_bits(1)), 8'(lo + take_bits(span_bits)), 23'(take_bits(23))};
   endfunction

   // Zero, subnormal, inf, NaN or a normal value
   function automatic logic [31:0] special_float();
      logic [2:0] cls;
      cls = take_bits(3);
      case (cls)
         3'd0:    return {1'(take_bits(1)), 31'h0};
         3'd1:    return {1'(take_bits(1)), 8'h00, 23'(take_bits(23)) | 23'h1};
         3'd2:    return {1'(take_bits(1)), 8'hFF, 23'h0};
         3'd3:    return {1'(take_bits(1)), 8'hFF, 23'(take_bits(23)) | 23'h1};
         default: return make_float(112, 5);
      endcase
   endfunction

   function automatic logic [3:0] arith_op();
      logic [1:0] r;
      r = take_bits(2);
      return (r == 2'd3) ? 4'h2 : {2'b00, r};
   endfunction

   always @(posedge Clk_CI)
   begin
      cycles++;
      if (cycles > CYCLE_LIMIT)
      begin
         $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   initial
   begin
      logic [31:0] x;
      logic        hi;
      repeat (2) @(posedge Clk_CI);
      #10 Rst_RBI = 1'b1;

      // Reset value and hold by enable and stall
      for (int i = 0; i < 3; i++) apply(make_float(100, 5), make_float(100, 5), 0, 0, 0, 0);
      apply(make_float(100, 5), make_float(100, 5), 0, 2, 1, 0);
      for (int i = 0; i < 4; i++) apply(make_float(100, 5), make_float(100, 5), 1, 0, 1, 1);
      for (int i = 0; i < 4; i++) apply(make_float(100, 5), make_float(100, 5), 2, 1, 1, 0);

      // Normal operands
      for (int i = 0; i < N_NORM; i++)
         apply(make_float(97, 6), make_float(97, 6), take_bits(2), arith_op(), 1, 0);

      // Near the ends of the exponent range
      for (int i = 0; i < N_RANGE; i++)
      begin
         hi = take_bits(1);
         apply(hi ? make_float(223, 5) : make_float(1, 5),
               hi ? make_float(223, 5) : make_float(1, 5), take_bits(2), arith_op(), 1, 0);
      end

      // Special operands
      for (int i = 0; i < N_SPEC; i++)
         apply(special_float(), special_float(), take_bits(2), arith_op(), 1, 0);

      // Cancellation and unknown codes
      for (int i = 0; i < N_CANC; i++)
      begin
         x = make_float(100, 5);
         if (take_bits(2) == 0)
            apply(x, make_float(100, 5), take_bits(2), 4'd3 + take_bits(4) % 13, 1, 0);
         else
            apply(x, x ^ take_bits(12), take_bits(2), 4'h1, 1, 0);
      end

      // Exact zero sums, sign depends on mode
      for (int i = 0; i < N_ZERO / 2; i++)
      begin
         x = make_float(100, 5);
         apply(x, x, i, 4'h1, 1, 0);
         apply(x, x ^ 32'h8000_0000, i, 4'h0, 1, 0);
      end

      // Random enable and stall over a stream
      for (int i = 0; i < N_STREAM; i++)
         apply(make_float(97, 6), make_float(97, 6), take_bits(2), arith_op(),
               take_bits(2) != 0, take_bits(2) == 0);

      // Drain
      for (int i = 0; i < N_DRAIN; i++) apply(32'h0, 32'h0, 0, 0, 0, 0);
      @(posedge Clk_CI);
      if (chk_i.expected_q.size() != 0)
      begin
         $display("%0d expected results were never loaded", chk_i.expected_q.size());
         other_errors++;
      end
      $display("Errors: %0d compare, %0d other, %0d loads, %0d checks",
               chk_i.errors, other_errors, chk_i.loads, chk_i.checks);
      if ((chk_i.errors == 0) && (other_errors == 0))
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: fpu.f
source/fpu_pkg.sv
source/fpu_add.sv
source/fpu_mult.sv
source/fpu_norm.sv
source/fpu_core.sv
source/fpu.sv
tb/fpu_checker.sv
tb/tb_fpu.sv

// File: Bender.yml
package:
  name: fpu

sources:
  - source/fpu_pkg.sv
  - source/fpu_add.sv
  - source/fpu_mult.sv
  - source/fpu_norm.sv
  - source/fpu_core.sv
  - source/fpu.sv
  - target: test
    files:
      - tb/fpu_checker.sv
      - tb/tb_fpu.sv
